//--- common/axi_up_pkg.sv
// Single-beat AXI subsystem only: 32-bit master, 128-bit memory, 16-bit addresses, 4 KiB memory
package axi_up_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------

  // Narrow master side
  localparam int unsigned NARROW_DATA_WIDTH = 32;
  // Wide memory side
  localparam int unsigned WIDE_DATA_WIDTH   = 128;
  // Byte address
  localparam int unsigned ADDR_WIDTH        = 16;
  localparam int unsigned ID_WIDTH          = 4;

  // Memory size in bytes, higher addresses answer with SLVERR
  localparam int unsigned MEM_BYTES         = 4096;

  // Byte offset inside one wide word
  localparam int unsigned LANE_SEL_WIDTH    = 4;

  // ----------------------------------------
  // Field types
  // ----------------------------------------

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [ID_WIDTH-1:0]   id_t;
  typedef logic [7:0]            len_t;
  typedef logic [2:0]            size_t;
  typedef logic [1:0]            burst_t;
  typedef logic [3:0]            cache_t;
  typedef logic [1:0]            resp_t;

  // Data and strobes per side
  typedef logic [NARROW_DATA_WIDTH-1:0]   narrow_data_t;
  typedef logic [NARROW_DATA_WIDTH/8-1:0] narrow_strb_t;
  typedef logic [WIDE_DATA_WIDTH-1:0]     wide_data_t;
  typedef logic [WIDE_DATA_WIDTH/8-1:0]   wide_strb_t;

  // ----------------------------------------
  // Response codes
  // ----------------------------------------

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- common/axi_bus_if.sv
// Single-beat AXI bus without lock, prot, qos, region or user; only the data width varies
`timescale 1ns/1ps

interface axi_bus_if #(
  parameter int unsigned DATA_WIDTH = 32
);

  // Write address
  axi_up_pkg::id_t    aw_id;
  axi_up_pkg::addr_t  aw_addr;
  axi_up_pkg::len_t   aw_len;
  axi_up_pkg::size_t  aw_size;
  axi_up_pkg::burst_t aw_burst;
  axi_up_pkg::cache_t aw_cache;
  logic               aw_valid;
  logic               aw_ready;

  // Write data
  logic [DATA_WIDTH-1:0]   w_data;
  logic [DATA_WIDTH/8-1:0] w_strb;
  logic                    w_last;
  logic                    w_valid;
  logic                    w_ready;

  // Write response
  axi_up_pkg::id_t   b_id;
  axi_up_pkg::resp_t b_resp;
  logic              b_valid;
  logic              b_ready;

  // Read address
  axi_up_pkg::id_t    ar_id;
  axi_up_pkg::addr_t  ar_addr;
  axi_up_pkg::len_t   ar_len;
  axi_up_pkg::size_t  ar_size;
  axi_up_pkg::burst_t ar_burst;
  axi_up_pkg::cache_t ar_cache;
  logic               ar_valid;
  logic               ar_ready;

  // Read data
  axi_up_pkg::id_t       r_id;
  logic [DATA_WIDTH-1:0] r_data;
  axi_up_pkg::resp_t     r_resp;
  logic                  r_last;
  logic                  r_valid;
  logic                  r_ready;

  modport master (
    output aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_cache, aw_valid,
    input  aw_ready,
    output w_data, w_strb, w_last, w_valid,
    input  w_ready,
    input  b_id, b_resp, b_valid,
    output b_ready,
    output ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_cache, ar_valid,
    input  ar_ready,
    input  r_id, r_data, r_resp, r_last, r_valid,
    output r_ready
  );

  modport slave (
    input  aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_cache, aw_valid,
    output aw_ready,
    input  w_data, w_strb, w_last, w_valid,
    output w_ready,
    output b_id, b_resp, b_valid,
    input  b_ready,
    input  ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_cache, ar_valid,
    output ar_ready,
    output r_id, r_data, r_resp, r_last, r_valid,
    input  r_ready
  );

endinterface

//--- upsize/axi_data_upsize.sv
// Single-beat upsizer: len 0, narrow size up to 4 bytes, one transaction per direction, no bursts
`timescale 1ns/1ps

module axi_data_upsize (
  input  logic      clk_i,
  input  logic      rst_ni,
  axi_bus_if.slave  in,
  axi_bus_if.master out
);

  typedef enum logic {
    R_IDLE,
    R_SINGLE
  } r_state_e;

  typedef enum logic {
    W_IDLE,
    W_SINGLE
  } w_state_e;

  r_state_e r_state_d, r_state_q;
  w_state_e w_state_d, w_state_q;

  // Byte offset of the addressed narrow lane, low bits cleared
  logic [axi_up_pkg::LANE_SEL_WIDTH-1:0] r_off_q, w_off_q;
  axi_up_pkg::id_t r_id_q, w_id_q;

  logic r_idle, w_idle;
  logic ar_hs, aw_hs, r_hs, b_hs;

  assign r_idle = (r_state_q == R_IDLE);
  assign w_idle = (w_state_q == W_IDLE);

  // ----------------------------------------
  // Read direction
  // ----------------------------------------

  // AR passes through while idle, size widened
  assign out.ar_id    = in.ar_id;
  assign out.ar_addr  = in.ar_addr;
  assign out.ar_len   = in.ar_len;
  assign out.ar_size  = axi_up_pkg::size_t'($clog2(axi_up_pkg::WIDE_DATA_WIDTH / 8));
  assign out.ar_burst = in.ar_burst;
  assign out.ar_cache = in.ar_cache;
  assign out.ar_valid = r_idle & in.ar_valid;
  assign in.ar_ready  = r_idle & out.ar_ready;

  // R only visible while a read is outstanding
  assign in.r_id      = out.r_id;
  assign in.r_resp    = out.r_resp;
  assign in.r_last    = out.r_last;
  assign in.r_valid   = ~r_idle & out.r_valid;
  assign out.r_ready  = ~r_idle & in.r_ready;
  // Pick the captured lane from the wide word
  assign in.r_data    = r_idle ? '0 : out.r_data[8*r_off_q +: axi_up_pkg::NARROW_DATA_WIDTH];

  assign ar_hs = out.ar_valid & out.ar_ready;
  assign r_hs  = in.r_valid & in.r_ready;

  always_comb begin
    r_state_d = r_state_q;
    case (r_state_q)
      R_IDLE:   if (ar_hs) r_state_d = R_SINGLE;
      R_SINGLE: if (r_hs) r_state_d = R_IDLE;
      default:  r_state_d = R_IDLE;
    endcase
  end

  // ----------------------------------------
  // Write direction
  // ----------------------------------------

  assign out.aw_id    = in.aw_id;
  assign out.aw_addr  = in.aw_addr;
  assign out.aw_len   = in.aw_len;
  assign out.aw_size  = axi_up_pkg::size_t'($clog2(axi_up_pkg::WIDE_DATA_WIDTH / 8));
  assign out.aw_burst = in.aw_burst;
  assign out.aw_cache = in.aw_cache;
  assign out.aw_valid = w_idle & in.aw_valid;
  assign in.aw_ready  = w_idle & out.aw_ready;

  assign out.w_last   = in.w_last;
  assign out.w_valid  = ~w_idle & in.w_valid;
  assign in.w_ready   = ~w_idle & out.w_ready;

  // Lane steering, other lanes keep zero strobes
  always_comb begin
    out.w_data = '0;
    out.w_strb = '0;
    if (!w_idle) begin
      out.w_data[8*w_off_q +: axi_up_pkg::NARROW_DATA_WIDTH]   = in.w_data;
      out.w_strb[w_off_q +: axi_up_pkg::NARROW_DATA_WIDTH / 8] = in.w_strb;
    end
  end

  // B answers with the id of the accepted write
  assign in.b_id      = w_id_q;
  assign in.b_resp    = out.b_resp;
  assign in.b_valid   = ~w_idle & out.b_valid;
  assign out.b_ready  = ~w_idle & in.b_ready;

  assign aw_hs = out.aw_valid & out.aw_ready;
  assign b_hs  = in.b_valid & in.b_ready;

  always_comb begin
    w_state_d = w_state_q;
    case (w_state_q)
      W_IDLE:   if (aw_hs) w_state_d = W_SINGLE;
      W_SINGLE: if (b_hs) w_state_d = W_IDLE;
      default:  w_state_d = W_IDLE;
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_state_q <= R_IDLE;
      w_state_q <= W_IDLE;
    end else begin
      r_state_q <= r_state_d;
      w_state_q <= w_state_d;
    end
  end

  // Offset and id captured on the address handshake
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      r_off_q <= {in.ar_addr[axi_up_pkg::LANE_SEL_WIDTH-1:2], 2'b00};
      r_id_q  <= in.ar_id;
    end
    if (aw_hs) begin
      w_off_q <= {in.aw_addr[axi_up_pkg::LANE_SEL_WIDTH-1:2], 2'b00};
      w_id_q  <= in.aw_id;
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  // Narrow requests never wider than the narrow bus
  a_narrow_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!in.ar_valid || in.ar_size <= 3'd2) && (!in.aw_valid || in.aw_size <= 3'd2));

  // Single beats only
  a_narrow_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!in.ar_valid || in.ar_len == '0) && (!in.aw_valid || in.aw_len == '0));

  // Memory answers only a read this side accepted
  a_r_valid_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out.r_valid |-> r_state_q == R_SINGLE);

  // Wide side echoes the ids of the accepted requests
  a_r_id_echo: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in.r_valid |-> out.r_id == r_id_q);

  a_b_id_echo: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in.b_valid |-> out.b_id == w_id_q);

endmodule

//--- hdl/axi_wide_mem.sv
// 4 KiB single-beat AXI memory, one transaction per direction, SLVERR above the memory size
`timescale 1ns/1ps

module axi_wide_mem (
  input  logic     clk_i,
  input  logic     rst_ni,
  axi_bus_if.slave slv
);

  typedef enum logic [1:0] {
    MW_IDLE,
    MW_DATA,
    MW_RESP
  } mw_state_e;

  typedef enum logic {
    MR_IDLE,
    MR_RESP
  } mr_state_e;

  mw_state_e mw_state_q;
  mr_state_e mr_state_q;

  // Word array, index from address bits above the lane offset
  axi_up_pkg::wide_data_t mem_q [axi_up_pkg::MEM_BYTES / (axi_up_pkg::WIDE_DATA_WIDTH / 8)];

  axi_up_pkg::addr_t      aw_addr_q, ar_addr_q;
  axi_up_pkg::id_t        aw_id_q, ar_id_q;
  axi_up_pkg::wide_data_t r_data_q;

  logic w_in_range, ar_in_range, r_in_range;
  logic aw_hs, w_hs, b_hs, ar_hs, r_hs;

  assign w_in_range  = aw_addr_q < axi_up_pkg::addr_t'(axi_up_pkg::MEM_BYTES);
  assign ar_in_range = slv.ar_addr < axi_up_pkg::addr_t'(axi_up_pkg::MEM_BYTES);
  assign r_in_range  = ar_addr_q < axi_up_pkg::addr_t'(axi_up_pkg::MEM_BYTES);

  // ----------------------------------------
  // Write channel
  // ----------------------------------------

  assign slv.aw_ready = (mw_state_q == MW_IDLE);
  assign slv.w_ready  = (mw_state_q == MW_DATA);
  assign slv.b_valid  = (mw_state_q == MW_RESP);
  assign slv.b_id     = aw_id_q;
  assign slv.b_resp   = w_in_range ? axi_up_pkg::RESP_OKAY : axi_up_pkg::RESP_SLVERR;

  assign aw_hs = slv.aw_valid & slv.aw_ready;
  assign w_hs  = slv.w_valid & slv.w_ready;
  assign b_hs  = slv.b_valid & slv.b_ready;

  // ----------------------------------------
  // Read channel
  // ----------------------------------------

  assign slv.ar_ready = (mr_state_q == MR_IDLE);
  assign slv.r_valid  = (mr_state_q == MR_RESP);
  assign slv.r_id     = ar_id_q;
  assign slv.r_data   = r_data_q;
  assign slv.r_resp   = r_in_range ? axi_up_pkg::RESP_OKAY : axi_up_pkg::RESP_SLVERR;
  assign slv.r_last   = 1'b1;

  assign ar_hs = slv.ar_valid & slv.ar_ready;
  assign r_hs  = slv.r_valid & slv.r_ready;

  // Both FSMs run independently
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mw_state_q <= MW_IDLE;
      mr_state_q <= MR_IDLE;
    end else begin
      case (mw_state_q)
        MW_IDLE: if (aw_hs) mw_state_q <= MW_DATA;
        MW_DATA: if (w_hs) mw_state_q <= MW_RESP;
        MW_RESP: if (b_hs) mw_state_q <= MW_IDLE;
        default: mw_state_q <= MW_IDLE;
      endcase
      case (mr_state_q)
        MR_IDLE: if (ar_hs) mr_state_q <= MR_RESP;
        MR_RESP: if (r_hs) mr_state_q <= MR_IDLE;
        default: mr_state_q <= MR_IDLE;
      endcase
    end
  end

  // Payload and array
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q <= slv.aw_addr;
      aw_id_q   <= slv.aw_id;
    end
    // Byte-enabled write, dropped when out of range
    if (w_hs && w_in_range) begin
      for (int i = 0; i < axi_up_pkg::WIDE_DATA_WIDTH / 8; i++) begin
        if (slv.w_strb[i]) begin
          mem_q[aw_addr_q[11:axi_up_pkg::LANE_SEL_WIDTH]][8*i +: 8] <= slv.w_data[8*i +: 8];
        end
      end
    end
    if (ar_hs) begin
      ar_addr_q <= slv.ar_addr;
      ar_id_q   <= slv.ar_id;
      r_data_q  <= ar_in_range ? mem_q[slv.ar_addr[11:axi_up_pkg::LANE_SEL_WIDTH]] : '0;
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv.b_valid && !slv.b_ready |=> slv.b_valid && $stable(slv.b_id) && $stable(slv.b_resp));

  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv.r_valid && !slv.r_ready |=>
      slv.r_valid && $stable(slv.r_data) && $stable(slv.r_id) && $stable(slv.r_resp));

endmodule

//--- hdl/axi_upsize_top.sv
// Narrow single-beat AXI slave ports into a 128-bit 4 KiB memory, no bursts, one request per direction
`timescale 1ns/1ps

module axi_upsize_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Write address
  input  axi_up_pkg::id_t          aw_id,
  input  axi_up_pkg::addr_t        aw_addr,
  input  axi_up_pkg::len_t         aw_len,
  input  axi_up_pkg::size_t        aw_size,
  input  axi_up_pkg::burst_t       aw_burst,
  input  axi_up_pkg::cache_t       aw_cache,
  input  logic                     aw_valid,
  output logic                     aw_ready,
  // Write data
  input  axi_up_pkg::narrow_data_t w_data,
  input  axi_up_pkg::narrow_strb_t w_strb,
  input  logic                     w_last,
  input  logic                     w_valid,
  output logic                     w_ready,
  // Write response
  output axi_up_pkg::id_t          b_id,
  output axi_up_pkg::resp_t        b_resp,
  output logic                     b_valid,
  input  logic                     b_ready,
  // Read address
  input  axi_up_pkg::id_t          ar_id,
  input  axi_up_pkg::addr_t        ar_addr,
  input  axi_up_pkg::len_t         ar_len,
  input  axi_up_pkg::size_t        ar_size,
  input  axi_up_pkg::burst_t       ar_burst,
  input  axi_up_pkg::cache_t       ar_cache,
  input  logic                     ar_valid,
  output logic                     ar_ready,
  // Read data
  output axi_up_pkg::id_t          r_id,
  output axi_up_pkg::narrow_data_t r_data,
  output axi_up_pkg::resp_t        r_resp,
  output logic                     r_last,
  output logic                     r_valid,
  input  logic                     r_ready
);

  axi_bus_if #(.DATA_WIDTH(axi_up_pkg::NARROW_DATA_WIDTH)) narrow_if ();
  axi_bus_if #(.DATA_WIDTH(axi_up_pkg::WIDE_DATA_WIDTH))   wide_if ();

  // ----------------------------------------
  // Plain ports onto the narrow bus
  // ----------------------------------------

  assign narrow_if.aw_id    = aw_id;
  assign narrow_if.aw_addr  = aw_addr;
  assign narrow_if.aw_len   = aw_len;
  assign narrow_if.aw_size  = aw_size;
  assign narrow_if.aw_burst = aw_burst;
  assign narrow_if.aw_cache = aw_cache;
  assign narrow_if.aw_valid = aw_valid;
  assign aw_ready           = narrow_if.aw_ready;

  assign narrow_if.w_data   = w_data;
  assign narrow_if.w_strb   = w_strb;
  assign narrow_if.w_last   = w_last;
  assign narrow_if.w_valid  = w_valid;
  assign w_ready            = narrow_if.w_ready;

  assign b_id               = narrow_if.b_id;
  assign b_resp             = narrow_if.b_resp;
  assign b_valid            = narrow_if.b_valid;
  assign narrow_if.b_ready  = b_ready;

  assign narrow_if.ar_id    = ar_id;
  assign narrow_if.ar_addr  = ar_addr;
  assign narrow_if.ar_len   = ar_len;
  assign narrow_if.ar_size  = ar_size;
  assign narrow_if.ar_burst = ar_burst;
  assign narrow_if.ar_cache = ar_cache;
  assign narrow_if.ar_valid = ar_valid;
  assign ar_ready           = narrow_if.ar_ready;

  assign r_id               = narrow_if.r_id;
  assign r_data             = narrow_if.r_data;
  assign r_resp             = narrow_if.r_resp;
  assign r_last             = narrow_if.r_last;
  assign r_valid            = narrow_if.r_valid;
  assign narrow_if.r_ready  = r_ready;

  // ----------------------------------------
  // Upsizer and memory
  // ----------------------------------------

  axi_data_upsize upsize_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in     (narrow_if.slave),
    .out    (wide_if.master)
  );

  axi_wide_mem mem_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .slv    (wide_if.slave)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running 40 ns clock; reset low from time zero for the first 8 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

endmodule

//--- testbench/axi_upsize_tb.sv
// One single-beat request at a time; memory words are read only after a write has set them
`timescale 1ns/1ps

module axi_upsize_tb;

  localparam int unsigned TIMEOUT_CYCLES = 64;

  typedef struct packed {
    axi_up_pkg::narrow_data_t data;
    axi_up_pkg::resp_t        resp;
    axi_up_pkg::id_t          id;
    logic                     last;
    logic                     is_read;
  } rsp_t;

  logic clk_i;
  logic rst_ni;
  axi_up_pkg::id_t          aw_id, b_id, ar_id, r_id;
  axi_up_pkg::addr_t        aw_addr, ar_addr;
  axi_up_pkg::len_t         aw_len, ar_len;
  axi_up_pkg::size_t        aw_size, ar_size;
  axi_up_pkg::burst_t       aw_burst, ar_burst;
  axi_up_pkg::cache_t       aw_cache, ar_cache;
  axi_up_pkg::narrow_data_t w_data, r_data;
  axi_up_pkg::narrow_strb_t w_strb;
  axi_up_pkg::resp_t        b_resp, r_resp;
  logic aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_last, r_valid, r_ready;

  logic [31:0] lfsr_q;
  // Shadow of the memory, byte granular
  logic [7:0]  shadow [axi_up_pkg::MEM_BYTES];
  int unsigned err_count, check_count, test_base;
  logic        timed_out;
  rsp_t        exp_q[$];
  rsp_t        obs_q[$];
  event        rsp_seen;

  tb_clock_gen clk_gen_i (.clk_i(clk_i), .rst_ni(rst_ni));

  axi_upsize_top dut_i (.*);

  // ----------------------------------------
  // Random source and reference model
  // ----------------------------------------

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic axi_up_pkg::resp_t ref_resp(input axi_up_pkg::addr_t a);
    return (32'(a) < axi_up_pkg::MEM_BYTES) ? axi_up_pkg::RESP_OKAY : axi_up_pkg::RESP_SLVERR;
  endfunction

  // Expected read word, zero above the memory
  function automatic axi_up_pkg::narrow_data_t ref_read(input axi_up_pkg::addr_t a);
    logic [11:0] idx;
    idx = {a[11:2], 2'b00};
    if (32'(a) >= axi_up_pkg::MEM_BYTES) return '0;
    return {shadow[idx + 12'd3], shadow[idx + 12'd2], shadow[idx + 12'd1], shadow[idx]};
  endfunction

  task automatic shadow_write(input axi_up_pkg::addr_t a, input axi_up_pkg::narrow_data_t d,
                              input axi_up_pkg::narrow_strb_t s);
    logic [11:0] idx;
    idx = {a[11:2], 2'b00};
    if (32'(a) < axi_up_pkg::MEM_BYTES) begin
      for (int i = 0; i < 4; i++) begin
        if (s[i]) shadow[idx + 12'(i)] = d[8*i +: 8];
      end
    end
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic compare_data(input string name, input axi_up_pkg::narrow_data_t got,
                              input axi_up_pkg::narrow_data_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_resp(input string name, input axi_up_pkg::resp_t got,
                              input axi_up_pkg::resp_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_id(input string name, input axi_up_pkg::id_t got,
                            input axi_up_pkg::id_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_last(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Observed responses against expectations taken at issue time
  initial begin
    rsp_t e;
    rsp_t o;
    forever begin
      @(rsp_seen);
      while (obs_q.size() > 0) begin
        o = obs_q.pop_front();
        if (exp_q.size() == 0) begin
          err_count++;
          $display("a response arrived with no request outstanding");
        end else begin
          e = exp_q.pop_front();
          if (o.is_read) begin
            compare_data("r_data", o.data, e.data);
            compare_last("r_last", o.last, e.last);
          end
          compare_resp(o.is_read ? "r_resp" : "b_resp", o.resp, e.resp);
          compare_id(o.is_read ? "r_id" : "b_id", o.id, e.id);
        end
      end
    end
  end

  // ----------------------------------------
  // Bus tasks
  // ----------------------------------------

  // Outputs depend on DUT state only, so a falling edge sees the value of the next rising edge
  function automatic logic output_level(input string name);
    if (name == "aw_ready") return aw_ready;
    if (name == "w_ready") return w_ready;
    if (name == "b_valid") return b_valid;
    if (name == "ar_ready") return ar_ready;
    return r_valid;
  endfunction

  task automatic wait_high(input string name);
    int unsigned n;
    n = 0;
    while (!output_level(name) && n < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    if (!output_level(name)) begin
      timed_out = 1'b1;
      err_count++;
      $display("%s did not go high within %0d cycles", name, TIMEOUT_CYCLES);
    end
  endtask

  task automatic check_idle();
    check_count++;
    if (b_valid !== 1'b0 || r_valid !== 1'b0 || w_ready !== 1'b0) begin
      err_count++;
      $display("error b_valid/r_valid/w_ready: got 0x%h/0x%h/0x%h, expected 0x0/0x0/0x0",
               b_valid, r_valid, w_ready);
    end
  endtask

  // AW and W raised together, b_ready held off for hold cycles
  task automatic write_word(input axi_up_pkg::addr_t a, input axi_up_pkg::narrow_data_t d,
                            input axi_up_pkg::narrow_strb_t s, input axi_up_pkg::id_t id,
                            input int hold);
    rsp_t e;
    rsp_t o;
    if (timed_out) return;
    e = '{data: '0, resp: ref_resp(a), id: id, last: 1'b0, is_read: 1'b0};
    exp_q.push_back(e);
    shadow_write(a, d, s);
    aw_addr  = a;
    aw_id    = id;
    aw_valid = 1'b1;
    w_data   = d;
    w_strb   = s;
    w_valid  = 1'b1;
    wait_high("aw_ready");
    if (timed_out) return;
    @(negedge clk_i);
    aw_valid = 1'b0;
    wait_high("w_ready");
    if (timed_out) return;
    @(negedge clk_i);
    w_valid = 1'b0;
    wait_high("b_valid");
    if (timed_out) return;
    o = '{data: '0, resp: b_resp, id: b_id, last: 1'b0, is_read: 1'b0};
    // Back-pressure, the response must hold
    repeat (hold) begin
      @(negedge clk_i);
      if (!b_valid) begin
        err_count++;
        $display("b_valid dropped while b_ready was low");
      end
      compare_resp("b_resp held", b_resp, o.resp);
      compare_id("b_id held", b_id, o.id);
    end
    b_ready = 1'b1;
    obs_q.push_back(o);
    -> rsp_seen;
    @(negedge clk_i);
    b_ready = 1'b0;
  endtask

  task automatic read_word(input axi_up_pkg::addr_t a, input axi_up_pkg::id_t id, input int hold);
    rsp_t e;
    rsp_t o;
    if (timed_out) return;
    // Single beat, so the only beat is the last
    e = '{data: ref_read(a), resp: ref_resp(a), id: id, last: 1'b1, is_read: 1'b1};
    exp_q.push_back(e);
    ar_addr  = a;
    ar_id    = id;
    ar_valid = 1'b1;
    wait_high("ar_ready");
    if (timed_out) return;
    @(negedge clk_i);
    ar_valid = 1'b0;
    wait_high("r_valid");
    if (timed_out) return;
    o = '{data: r_data, resp: r_resp, id: r_id, last: r_last, is_read: 1'b1};
    repeat (hold) begin
      @(negedge clk_i);
      if (!r_valid) begin
        err_count++;
        $display("r_valid dropped while r_ready was low");
      end
      compare_data("r_data held", r_data, o.data);
      compare_resp("r_resp held", r_resp, o.resp);
      compare_id("r_id held", r_id, o.id);
    end
    r_ready = 1'b1;
    obs_q.push_back(o);
    -> rsp_seen;
    @(negedge clk_i);
    r_ready = 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, err_count - test_base);
    test_base = err_count;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    logic [31:0]              v;
    axi_up_pkg::addr_t        a;
    axi_up_pkg::narrow_data_t d;
    axi_up_pkg::narrow_strb_t s;
    axi_up_pkg::id_t          id;
    int                       hold;
    int unsigned              n;
    lfsr_q      = 32'h3538_118b;
    err_count   = 0;
    check_count = 0;
    test_base   = 0;
    timed_out   = 1'b0;
    // Single beats of 4 bytes, INCR
    aw_id    = '0;
    aw_addr  = '0;
    aw_len   = '0;
    aw_size  = 3'd2;
    aw_burst = 2'b01;
    aw_cache = '0;
    aw_valid = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b1;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_id    = '0;
    ar_addr  = '0;
    ar_len   = '0;
    ar_size  = 3'd2;
    ar_burst = 2'b01;
    ar_cache = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;

    // Responses and w_ready quiet through reset and after it
    n = 0;
    while (rst_ni !== 1'b1 && n < 32) begin
      @(negedge clk_i);
      check_idle();
      n++;
    end
    if (rst_ni !== 1'b1) begin
      timed_out = 1'b1;
      err_count++;
      $display("reset was never released");
    end
    repeat (4) begin
      @(negedge clk_i);
      check_idle();
    end
    end_test("reset_idle");

    rand_bits(32, v);
    d = v;
    write_word(16'h0040, d, 4'hF, 4'h3, 0);
    read_word(16'h0040, 4'h5, 0);
    end_test("write_read");

    // Four lanes of the wide line at 0x0100
    for (int i = 0; i < 4; i++) begin
      write_word({10'h004, 4'(i), 2'b00}, 32'h1111_1111 * 32'(i + 1), 4'hF, 4'(i), 0);
    end
    for (int i = 0; i < 4; i++) begin
      read_word({10'h004, 4'(i), 2'b00}, 4'(i + 8), 1);
    end
    end_test("lane_steering");

    rand_bits(32, v);
    write_word(16'h0084, v, 4'hF, 4'h1, 0);
    rand_bits(32, v);
    write_word(16'h0084, v, 4'b0110, 4'h2, 0);
    read_word(16'h0084, 4'h3, 0);
    end_test("partial_strobe");

    // 0x1014 would alias 0x0014 if the range check failed
    write_word(16'h0014, 32'h0BAD_C0DE, 4'hF, 4'h4, 0);
    write_word(16'h1014, 32'hDEAD_BEEF, 4'hF, 4'h6, 0);
    read_word(16'h1014, 4'h7, 0);
    read_word(16'h0014, 4'h9, 0);
    end_test("out_of_range");

    // Window 0x0200..0x023C, filled first so every read is defined
    for (int i = 0; i < 16; i++) begin
      rand_bits(32, v);
      write_word({8'h02, 2'b00, 4'(i), 2'b00}, v, 4'hF, 4'h0, 0);
    end
    for (int k = 0; k < 48; k++) begin
      rand_bits(4, v);
      a = {8'h02, 2'b00, v[3:0], 2'b00};
      rand_bits(32, v);
      d = v;
      rand_bits(4, v);
      s = v[3:0];
      rand_bits(4, v);
      id = v[3:0];
      rand_bits(2, v);
      hold = 32'(v[1:0]);
      rand_bits(1, v);
      if (v[0]) begin
        write_word(a, d, s, id, hold);
      end else begin
        read_word(a, id, hold);
      end
    end
    end_test("random_traffic");

    if (exp_q.size() != 0) begin
      err_count++;
      $display("%0d responses never arrived", exp_q.size());
    end
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- project.f
common/axi_up_pkg.sv
common/axi_bus_if.sv
upsize/axi_data_upsize.sv
hdl/axi_wide_mem.sv
hdl/axi_upsize_top.sv
testbench/tb_clock_gen.sv
testbench/axi_upsize_tb.sv

//--- Makefile
# Verilator build and run of the AXI upsizer testbench

VERILATOR ?= verilator
TOP       ?= axi_upsize_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build sim lint clean

all: sim

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
